// ==== rtl/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data and address width
`define CPU_XLEN 32

// General purpose registers, r0 hardwired to zero
`define CPU_REG_NUM 32

// Boot vector, kseg1 start of the boot ROM
`define CPU_RESET_PC 32'hBFC00000

`endif

// ==== rtl/cpu_pkg.sv ====
`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t; // Data or address word
    typedef logic [4:0] reg_id_t;
    typedef logic [31:0] instr_t;

    // ALU operations for the kept integer subset
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    // Wishbone classic read, one transfer at a time
    typedef enum logic {
        fetch_idle,
        fetch_wait_ack
    } fetch_state_e;

endpackage

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module fetch_stage (
    input  logic            Clk,
    input  logic            Myreset,
    input  cpu_pkg::instr_t i_wb_dat,
    input  logic            i_wb_ack,
    output logic            o_wb_cyc,
    output logic            o_wb_stb,
    output cpu_pkg::word_t  o_wb_adr,
    output cpu_pkg::instr_t o_instr,
    output cpu_pkg::word_t  o_pc,
    output logic            o_valid
);

    cpu_pkg::fetch_state_e state;
    cpu_pkg::word_t        pc;
    logic                  ack_fire;

    assign ack_fire = (state == cpu_pkg::fetch_wait_ack) && i_wb_ack;

    // One read in flight, one idle cycle between reads
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            state <= cpu_pkg::fetch_idle;
            pc    <= `CPU_RESET_PC;
        end else begin
            case (state)
                cpu_pkg::fetch_idle: begin
                    state <= cpu_pkg::fetch_wait_ack;
                end
                cpu_pkg::fetch_wait_ack: begin
                    if (i_wb_ack) begin
                        state <= cpu_pkg::fetch_idle;
                        pc    <= pc + cpu_pkg::word_t'(4); // Sequential only
                    end
                end
                default: begin
                    state <= cpu_pkg::fetch_idle;
                end
            endcase
        end
    end

    // Bus outputs decoded from state, address held until ack
    assign o_wb_cyc = (state == cpu_pkg::fetch_wait_ack);
    assign o_wb_stb = (state == cpu_pkg::fetch_wait_ack);
    assign o_wb_adr = pc;

    // Instruction register
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= ack_fire; // One cycle pulse per fetched word
        end
    end

    always_ff @(posedge Clk) begin
        if (ack_fire) begin
            o_instr <= i_wb_dat;
            o_pc    <= pc;
        end
    end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module reg_file (
    input  logic             Clk,
    input  logic             Myreset,
    input  cpu_pkg::reg_id_t i_rs_id,
    input  cpu_pkg::reg_id_t i_rt_id,
    input  logic             i_we,
    input  cpu_pkg::reg_id_t i_wr_id,
    input  cpu_pkg::word_t   i_wr_data,
    output cpu_pkg::word_t   o_rs_data,
    output cpu_pkg::word_t   o_rt_data
);

    cpu_pkg::word_t regs [`CPU_REG_NUM];

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            for (int i = 0; i < `CPU_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_wr_id != '0)) begin
            regs[i_wr_id] <= i_wr_data;
        end
    end

    // r0 reads zero, same-cycle write is passed through
    assign o_rs_data = (i_rs_id == '0) ? '0 :
                       (i_we && (i_wr_id == i_rs_id)) ? i_wr_data :
                       regs[i_rs_id];

    assign o_rt_data = (i_rt_id == '0) ? '0 :
                       (i_we && (i_wr_id == i_rt_id)) ? i_wr_data :
                       regs[i_rt_id];

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage (
    input  logic              Clk,
    input  logic              Myreset,
    input  cpu_pkg::instr_t   i_instr,
    input  cpu_pkg::word_t    i_pc,
    input  logic              i_valid,
    input  cpu_pkg::word_t    i_rs_data,
    input  cpu_pkg::word_t    i_rt_data,
    input  logic              i_ex_wen,
    input  cpu_pkg::reg_id_t  i_ex_rd,
    input  cpu_pkg::word_t    i_ex_result,
    output cpu_pkg::reg_id_t  o_rs_id,
    output cpu_pkg::reg_id_t  o_rt_id,
    output cpu_pkg::alu_op_e  o_alu_op,
    output cpu_pkg::word_t    o_op_a,
    output cpu_pkg::word_t    o_op_b,
    output cpu_pkg::reg_id_t  o_rd,
    output logic              o_wen,
    output cpu_pkg::word_t    o_pc,
    output logic              o_valid
);

    logic [5:0]       opcode;
    logic [5:0]       funct;
    logic [4:0]       shamt;
    logic [15:0]      imm;
    cpu_pkg::reg_id_t rd_field;
    cpu_pkg::alu_op_e alu_op;
    logic             known;
    logic             is_rtype;
    logic             is_shift;
    logic             sign_ext;
    cpu_pkg::word_t   rs_fwd;
    cpu_pkg::word_t   rt_fwd;
    cpu_pkg::word_t   imm_ext;
    cpu_pkg::reg_id_t dest;

    assign opcode   = i_instr[31:26];
    assign o_rs_id  = i_instr[25:21];
    assign o_rt_id  = i_instr[20:16];
    assign rd_field = i_instr[15:11];
    assign shamt    = i_instr[10:6];
    assign funct    = i_instr[5:0];
    assign imm      = i_instr[15:0];

    always_comb begin
        alu_op   = cpu_pkg::alu_add;
        known    = 1'b1;
        is_rtype = 1'b0;
        is_shift = 1'b0;
        sign_ext = 1'b0;
        if (opcode == 6'b000000) begin // SPECIAL
            is_rtype = 1'b1;
            case (funct)
                6'b000000: begin alu_op = cpu_pkg::alu_sll; is_shift = 1'b1; end
                6'b000010: begin alu_op = cpu_pkg::alu_srl; is_shift = 1'b1; end
                6'b000011: begin alu_op = cpu_pkg::alu_sra; is_shift = 1'b1; end
                6'b100001: alu_op = cpu_pkg::alu_add;
                6'b100011: alu_op = cpu_pkg::alu_sub;
                6'b100100: alu_op = cpu_pkg::alu_and;
                6'b100101: alu_op = cpu_pkg::alu_or;
                6'b100110: alu_op = cpu_pkg::alu_xor;
                6'b100111: alu_op = cpu_pkg::alu_nor;
                6'b101010: alu_op = cpu_pkg::alu_slt;
                6'b101011: alu_op = cpu_pkg::alu_sltu;
                default:   known = 1'b0;
            endcase
        end else begin
            case (opcode)
                6'b001001: begin alu_op = cpu_pkg::alu_add;  sign_ext = 1'b1; end
                6'b001010: begin alu_op = cpu_pkg::alu_slt;  sign_ext = 1'b1; end
                6'b001011: begin alu_op = cpu_pkg::alu_sltu; sign_ext = 1'b1; end
                6'b001100: alu_op = cpu_pkg::alu_and;
                6'b001101: alu_op = cpu_pkg::alu_or;
                6'b001110: alu_op = cpu_pkg::alu_xor;
                6'b001111: alu_op = cpu_pkg::alu_lui;
                default:   known = 1'b0;
            endcase
        end
    end

    // Execute result wins over the register file
    assign rs_fwd = (i_ex_wen && (i_ex_rd != '0) && (i_ex_rd == o_rs_id)) ?
                    i_ex_result : i_rs_data;
    assign rt_fwd = (i_ex_wen && (i_ex_rd != '0) && (i_ex_rd == o_rt_id)) ?
                    i_ex_result : i_rt_data;

    assign imm_ext = sign_ext ? cpu_pkg::word_t'($signed(imm)) : cpu_pkg::word_t'(imm);
    assign dest    = is_rtype ? rd_field : o_rt_id;

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            o_valid <= 1'b0;
            o_wen   <= 1'b0;
        end else begin
            o_valid <= i_valid;
            o_wen   <= i_valid && known && (dest != '0); // Bubble otherwise
        end
    end

    always_ff @(posedge Clk) begin
        o_alu_op <= alu_op;
        o_op_a   <= is_shift ? cpu_pkg::word_t'(shamt) : rs_fwd;
        o_op_b   <= is_rtype ? rt_fwd : imm_ext;
        o_rd     <= dest;
        o_pc     <= i_pc;
    end

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
    input  logic              Clk,
    input  logic              Myreset,
    input  cpu_pkg::alu_op_e  i_alu_op,
    input  cpu_pkg::word_t    i_op_a,
    input  cpu_pkg::word_t    i_op_b,
    input  cpu_pkg::reg_id_t  i_rd,
    input  logic              i_wen,
    input  cpu_pkg::word_t    i_pc,
    input  logic              i_valid,
    output cpu_pkg::word_t    o_ex_result,
    output logic              o_ex_wen,
    output cpu_pkg::word_t    o_wb_pc,
    output cpu_pkg::reg_id_t  o_wb_rd,
    output cpu_pkg::word_t    o_wb_data,
    output logic              o_wb_wen
);

    cpu_pkg::word_t result;
    logic [4:0]     sa;

    assign sa = i_op_a[4:0]; // Shift amount from shamt

    always_comb begin
        case (i_alu_op)
            cpu_pkg::alu_add:  result = i_op_a + i_op_b;
            cpu_pkg::alu_sub:  result = i_op_a - i_op_b;
            cpu_pkg::alu_and:  result = i_op_a & i_op_b;
            cpu_pkg::alu_or:   result = i_op_a | i_op_b;
            cpu_pkg::alu_xor:  result = i_op_a ^ i_op_b;
            cpu_pkg::alu_nor:  result = ~(i_op_a | i_op_b);
            cpu_pkg::alu_slt:  result = cpu_pkg::word_t'($signed(i_op_a) < $signed(i_op_b));
            cpu_pkg::alu_sltu: result = cpu_pkg::word_t'(i_op_a < i_op_b);
            cpu_pkg::alu_sll:  result = i_op_b << sa;
            cpu_pkg::alu_srl:  result = i_op_b >> sa;
            cpu_pkg::alu_sra:  result = cpu_pkg::word_t'($signed(i_op_b) >>> sa);
            cpu_pkg::alu_lui:  result = i_op_b << 16; // Immediate to upper half
            default:           result = '0;
        endcase
    end

    // Forwarding source for decode
    assign o_ex_result = result;
    assign o_ex_wen    = i_valid && i_wen;

    // Writeback register
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            o_wb_wen <= 1'b0;
        end else begin
            o_wb_wen <= o_ex_wen;
        end
    end

    always_ff @(posedge Clk) begin
        o_wb_pc   <= i_pc;
        o_wb_rd   <= i_rd;
        o_wb_data <= result;
    end

endmodule

// ==== rtl/cpu_top.sv ====
`timescale 1ns/100ps

module cpu_top (
    input  logic             Clk,
    input  logic             Myreset,
    input  cpu_pkg::instr_t  i_wb_dat,
    input  logic             i_wb_ack,
    output logic             o_wb_cyc,
    output logic             o_wb_stb,
    output cpu_pkg::word_t   o_wb_adr,
    output cpu_pkg::word_t   o_debug_wb_pc,
    output logic [3:0]       o_debug_wb_rf_wen,
    output cpu_pkg::reg_id_t o_debug_wb_rf_wnum,
    output cpu_pkg::word_t   o_debug_wb_rf_wdata
);

    // Fetch to decode
    cpu_pkg::instr_t  f_instr;
    cpu_pkg::word_t   f_pc;
    logic             f_valid;

    // Decode to register file
    cpu_pkg::reg_id_t rs_id;
    cpu_pkg::reg_id_t rt_id;
    cpu_pkg::word_t   rs_data;
    cpu_pkg::word_t   rt_data;

    // Decode to execute
    cpu_pkg::alu_op_e d_alu_op;
    cpu_pkg::word_t   d_op_a;
    cpu_pkg::word_t   d_op_b;
    cpu_pkg::reg_id_t d_rd;
    logic             d_wen;
    cpu_pkg::word_t   d_pc;
    logic             d_valid;

    // Execute forwarding and writeback
    cpu_pkg::word_t   ex_result;
    logic             ex_wen;
    cpu_pkg::word_t   wb_pc;
    cpu_pkg::reg_id_t wb_rd;
    cpu_pkg::word_t   wb_data;
    logic             wb_wen;

    fetch_stage u_fetch (
        .Clk, .Myreset, .i_wb_dat, .i_wb_ack, .o_wb_cyc, .o_wb_stb, .o_wb_adr,
        .o_instr(f_instr), .o_pc(f_pc), .o_valid(f_valid)
    );

    reg_file u_rf (
        .Clk, .Myreset, .i_rs_id(rs_id), .i_rt_id(rt_id),
        .i_we(wb_wen), .i_wr_id(wb_rd), .i_wr_data(wb_data),
        .o_rs_data(rs_data), .o_rt_data(rt_data)
    );

    decode_stage u_decode (
        .Clk, .Myreset, .i_instr(f_instr), .i_pc(f_pc), .i_valid(f_valid),
        .i_rs_data(rs_data), .i_rt_data(rt_data),
        .i_ex_wen(ex_wen), .i_ex_rd(d_rd), .i_ex_result(ex_result),
        .o_rs_id(rs_id), .o_rt_id(rt_id), .o_alu_op(d_alu_op),
        .o_op_a(d_op_a), .o_op_b(d_op_b), .o_rd(d_rd), .o_wen(d_wen),
        .o_pc(d_pc), .o_valid(d_valid)
    );

    execute_stage u_execute (
        .Clk, .Myreset, .i_alu_op(d_alu_op), .i_op_a(d_op_a), .i_op_b(d_op_b),
        .i_rd(d_rd), .i_wen(d_wen), .i_pc(d_pc), .i_valid(d_valid),
        .o_ex_result(ex_result), .o_ex_wen(ex_wen),
        .o_wb_pc(wb_pc), .o_wb_rd(wb_rd), .o_wb_data(wb_data), .o_wb_wen(wb_wen)
    );

    // Trace straight from the writeback register
    assign o_debug_wb_pc       = wb_pc;
    assign o_debug_wb_rf_wen   = {4{wb_wen}};
    assign o_debug_wb_rf_wnum  = wb_rd;
    assign o_debug_wb_rf_wdata = wb_data;

endmodule

// ==== tb/cpu_assertions.sv ====
`timescale 1ns/100ps

module cpu_assertions (
    input logic             Clk,
    input logic             Myreset,
    input logic             o_wb_cyc,
    input logic             o_wb_stb,
    input cpu_pkg::word_t   o_wb_adr,
    input logic             i_wb_ack,
    input logic [3:0]       o_debug_wb_rf_wen
);

    int fail_cnt = 0; // Failed assertions so far

    // Wishbone classic rules
    assert property (@(posedge Clk) disable iff (Myreset)
        o_wb_stb |-> o_wb_cyc)
    else begin
        $error("stb high without cyc");
        fail_cnt++;
    end

    assert property (@(posedge Clk) disable iff (Myreset)
        (o_wb_stb && !i_wb_ack) |=> (o_wb_stb && $stable(o_wb_adr)))
    else begin
        $error("address moved or stb dropped before ack");
        fail_cnt++;
    end

    assert property (@(posedge Clk) disable iff (Myreset)
        o_wb_stb |-> (o_wb_adr[1:0] == 2'b00))
    else begin
        $error("fetch address not word aligned");
        fail_cnt++;
    end

    // Trace byte enables move together
    assert property (@(posedge Clk) disable iff (Myreset)
        (o_debug_wb_rf_wen == 4'h0) || (o_debug_wb_rf_wen == 4'hF))
    else begin
        $error("trace write enable is partial");
        fail_cnt++;
    end

endmodule

// ==== tb/cpu_tb.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_tb;

    localparam int PROG_LEN       = 200;
    localparam int MEM_WORDS      = 256;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 8 + 50;

    logic             Clk = 1'b0;
    logic             Myreset;
    cpu_pkg::instr_t  i_wb_dat;
    logic             i_wb_ack;
    logic             o_wb_cyc;
    logic             o_wb_stb;
    cpu_pkg::word_t   o_wb_adr;
    cpu_pkg::word_t   o_debug_wb_pc;
    logic [3:0]       o_debug_wb_rf_wen;
    cpu_pkg::reg_id_t o_debug_wb_rf_wnum;
    cpu_pkg::word_t   o_debug_wb_rf_wdata;

    integer          seed = 17;
    cpu_pkg::instr_t prog [MEM_WORDS];
    int              ack_edge [MEM_WORDS];
    cpu_pkg::word_t  model_regs [32];
    int              model_idx = 0;
    int              edge_cnt = 0;
    int              cycle_cnt = 0;
    int              acks_seen = 0;
    int              checks = 0;
    int              traces = 0;
    int              errors = 0;
    cpu_pkg::word_t  next_adr = `CPU_RESET_PC;
    logic            busy = 1'b0;
    int              wait_left = 0;

    cpu_top dut0 (.*);

    bind cpu_top cpu_assertions u_assertions (.*);

    always #10 Clk = ~Clk;

    function automatic cpu_pkg::instr_t encode_rtype(input int rs, input int rt, input int rd,
                                                     input int sh, input logic [5:0] fn);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic cpu_pkg::instr_t encode_itype(input logic [5:0] op, input int rs,
                                                     input int rt, input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    // Small register range keeps dependencies and r0 writes frequent
    function automatic cpu_pkg::instr_t random_word();
        int          kind;
        int          rs;
        int          rt;
        int          rd;
        int          sh;
        logic [15:0] imm;
        logic [5:0]  fn;
        kind = {$random(seed)} % 20;
        rs   = {$random(seed)} % 8;
        rt   = {$random(seed)} % 8;
        rd   = {$random(seed)} % 8;
        sh   = {$random(seed)} % 32;
        imm  = $random(seed);
        case (kind)
            0: fn = 6'h21;
            1: fn = 6'h23;
            2: fn = 6'h24;
            3: fn = 6'h25;
            4: fn = 6'h26;
            5: fn = 6'h27;
            6: fn = 6'h2A;
            default: fn = 6'h2B;
        endcase
        if (kind < 8) return encode_rtype(rs, rt, rd, 0, fn);
        if (kind == 8) return encode_rtype(0, rt, rd, sh, 6'h00);
        if (kind == 9) return encode_rtype(0, rt, rd, sh, 6'h02);
        if (kind == 10) return encode_rtype(0, rt, rd, sh, 6'h03);
        if (kind < 18) return encode_itype(6'(kind - 2), rs, rt, imm); // addiu to lui
        if (kind == 18) return encode_itype(6'h2B, rs, rt, imm); // sw is outside the subset
        return encode_rtype(rs, rt, rd, 0, 6'h20); // Trapping add is outside the subset
    endfunction

    // MIPS semantics of the kept subset on the model registers
    function automatic logic ref_execute(input cpu_pkg::instr_t instr,
                                         output cpu_pkg::reg_id_t wnum,
                                         output cpu_pkg::word_t wdata);
        logic [5:0]     op;
        logic [5:0]     fn;
        logic [4:0]     sh;
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        cpu_pkg::word_t sext;
        cpu_pkg::word_t zext;
        logic           ok;
        op    = instr[31:26];
        fn    = instr[5:0];
        sh    = instr[10:6];
        a     = model_regs[instr[25:21]];
        b     = model_regs[instr[20:16]];
        sext  = {{16{instr[15]}}, instr[15:0]};
        zext  = {16'h0000, instr[15:0]};
        ok    = 1'b1;
        wdata = '0;
        if (op == 6'h00) begin
            wnum = instr[15:11];
            case (fn)
                6'h00: wdata = b << sh;
                6'h02: wdata = b >> sh;
                6'h03: wdata = $signed(b) >>> sh;
                6'h21: wdata = a + b;
                6'h23: wdata = a - b;
                6'h24: wdata = a & b;
                6'h25: wdata = a | b;
                6'h26: wdata = a ^ b;
                6'h27: wdata = ~(a | b);
                6'h2A: wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                6'h2B: wdata = (a < b) ? 32'd1 : 32'd0;
                default: ok = 1'b0;
            endcase
        end else begin
            wnum = instr[20:16];
            case (op)
                6'h09: wdata = a + sext;
                6'h0A: wdata = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
                6'h0B: wdata = (a < sext) ? 32'd1 : 32'd0;
                6'h0C: wdata = a & zext;
                6'h0D: wdata = a | zext;
                6'h0E: wdata = a ^ zext;
                6'h0F: wdata = {instr[15:0], 16'h0000};
                default: ok = 1'b0;
            endcase
        end
        if (ok && (wnum != 5'd0)) begin
            model_regs[wnum] = wdata;
            return 1'b1;
        end
        return 1'b0; // Bubble leaves the model untouched
    endfunction

    function automatic cpu_pkg::instr_t read_word(input cpu_pkg::word_t adr);
        cpu_pkg::word_t idx;
        idx = (adr - `CPU_RESET_PC) >> 2;
        if ((adr >= `CPU_RESET_PC) && (idx < MEM_WORDS)) return prog[idx];
        return '0;
    endfunction

    task automatic build_program();
        for (int i = 0; i < MEM_WORDS; i++) prog[i] = '0; // sll $0 past the end
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        prog[0]  = encode_itype(6'h0F, 0, 1, 16'h8001);  // lui r1
        prog[1]  = encode_itype(6'h0D, 1, 1, 16'h8234);  // ori with zero extension
        prog[2]  = encode_itype(6'h09, 1, 2, 16'hFFFF);  // addiu -1
        prog[3]  = encode_itype(6'h0A, 1, 3, 16'h0001);
        prog[4]  = encode_itype(6'h0B, 1, 4, 16'hFFFF);
        prog[5]  = encode_itype(6'h0C, 1, 5, 16'hFFFF);
        prog[6]  = encode_itype(6'h0E, 5, 6, 16'hFFFF);
        prog[7]  = encode_rtype(0, 1, 7, 4, 6'h03);      // sra
        prog[8]  = encode_rtype(0, 1, 8, 31, 6'h02);
        prog[9]  = encode_rtype(0, 6, 9, 7, 6'h00);
        prog[10] = encode_rtype(1, 2, 10, 0, 6'h2A);
        prog[11] = encode_rtype(2, 1, 11, 0, 6'h2B);
        prog[12] = encode_rtype(5, 1, 12, 0, 6'h23);
        prog[13] = encode_rtype(12, 0, 13, 0, 6'h27);
        prog[14] = encode_rtype(1, 2, 0, 0, 6'h21);      // Writes r0
        prog[15] = encode_itype(6'h09, 0, 0, 16'h0005);
        prog[16] = 32'h8C220000;                         // lw
        prog[17] = encode_rtype(1, 2, 14, 0, 6'h20);
        prog[18] = encode_rtype(13, 1, 14, 0, 6'h26);
        prog[19] = encode_rtype(14, 1, 15, 0, 6'h24);
        for (int i = 20; i < PROG_LEN; i++) prog[i] = random_word();
    endtask

    // Next retiring instruction of the model against the trace
    task automatic check_trace();
        logic             found;
        cpu_pkg::reg_id_t exp_num;
        cpu_pkg::word_t   exp_data;
        cpu_pkg::word_t   exp_pc;
        cpu_pkg::word_t   idx;
        found  = 1'b0;
        exp_pc = '0;
        while (!found && (model_idx < PROG_LEN)) begin
            exp_pc = `CPU_RESET_PC + model_idx * 4;
            found  = ref_execute(prog[model_idx], exp_num, exp_data);
            model_idx++;
        end
        traces++;
        checks++;
        if (!found) begin
            errors++;
            $display("Trace entry at pc %h has no instruction left in the program to match",
                     o_debug_wb_pc);
        end else begin
            if (o_debug_wb_pc !== exp_pc) begin
                errors++;
                $display("FAILED %0t: trace pc %h, expected %h", $time, o_debug_wb_pc, exp_pc);
            end
            if (o_debug_wb_rf_wnum !== exp_num) begin
                errors++;
                $display("FAILED %0t: pc %h wnum %0d, expected %0d", $time, exp_pc,
                         o_debug_wb_rf_wnum, exp_num);
            end
            if (o_debug_wb_rf_wdata !== exp_data) begin
                errors++;
                $display("FAILED %0t: pc %h wdata %h, expected %h", $time, exp_pc,
                         o_debug_wb_rf_wdata, exp_data);
            end
            idx = (exp_pc - `CPU_RESET_PC) >> 2;
            if (edge_cnt != ack_edge[idx] + 3) begin
                errors++;
                $display("FAILED %0t: pc %h traced %0d edges after its ack, expected 3",
                         $time, exp_pc, edge_cnt - ack_edge[idx]);
            end
        end
    endtask

    task automatic end_run();
        int total;
        total = errors + dut0.u_assertions.fail_cnt;
        $display("Checks: %0d, trace entries: %0d, errors: %0d", checks, traces, total);
        if (total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    // Slave with 0 to 3 wait states per read
    always @(negedge Clk) begin
        if (i_wb_ack) begin
            i_wb_ack = 1'b0;
            busy     = 1'b0;
        end else if (o_wb_cyc && o_wb_stb) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = $random(seed) & 3;
            end
            if (wait_left == 0) begin
                i_wb_ack = 1'b1;
                i_wb_dat = read_word(o_wb_adr);
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    always @(posedge Clk) begin : monitor
        cpu_pkg::word_t idx;
        if (!Myreset) begin
            edge_cnt++;
            if (o_wb_cyc && o_wb_stb && i_wb_ack) begin
                checks++;
                if (o_wb_adr !== next_adr) begin
                    errors++;
                    $display("FAILED %0t: fetch address %h, expected %h", $time,
                             o_wb_adr, next_adr);
                end
                idx = (o_wb_adr - `CPU_RESET_PC) >> 2;
                if (idx < MEM_WORDS) ack_edge[idx] = edge_cnt;
                next_adr = next_adr + 4;
                acks_seen++;
            end
            if (o_debug_wb_rf_wen != 4'h0) check_trace();
        end
    end

    always @(posedge Clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            errors++;
            $display("Timeout after %0d cycles, the program did not finish fetching", cycle_cnt);
            end_run();
        end
    end

    initial begin
        cpu_pkg::reg_id_t num;
        cpu_pkg::word_t   data;
        Myreset  = 1'b1;
        i_wb_ack = 1'b0;
        i_wb_dat = '0;
        build_program();
        repeat (2) @(posedge Clk);
        @(negedge Clk);
        Myreset = 1'b0;
        checks++;
        if (o_wb_cyc !== 1'b0 || o_wb_stb !== 1'b0 || o_debug_wb_rf_wen !== 4'h0) begin
            errors++;
            $display("FAILED %0t: cyc %b stb %b trace wen %h after reset", $time,
                     o_wb_cyc, o_wb_stb, o_debug_wb_rf_wen);
        end
        while (acks_seen < PROG_LEN + 4) @(posedge Clk);
        repeat (6) @(posedge Clk); // Drain the pipeline
        while (model_idx < PROG_LEN) begin
            if (ref_execute(prog[model_idx], num, data)) begin
                errors++;
                $display("Instruction at pc %h never appeared on the trace",
                         `CPU_RESET_PC + model_idx * 4);
            end
            model_idx++;
        end
        end_run();
    end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/cpu_top.sv
tb/cpu_assertions.sv
tb/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/cpu_pkg.sv
      - rtl/fetch_stage.sv
      - rtl/reg_file.sv
      - rtl/decode_stage.sv
      - rtl/execute_stage.sv
      - rtl/cpu_top.sv
  - target: test
    files:
      - tb/cpu_assertions.sv
      - tb/cpu_tb.sv
